/* include/csr_macros.svh */
// Shared widths, CSR addresses and field positions for the machine CSR file
// Included by every RTL module and by the testbench
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define CSR_XLEN   32
`define CSR_ADDR_W 12

// Machine trap setup and handling
`define CSR_MSTATUS       12'h300
`define CSR_MISA          12'h301
`define CSR_MIE           12'h304
`define CSR_MTVEC         12'h305
`define CSR_MCOUNTEREN    12'h306
`define CSR_MSTATUSH      12'h310
`define CSR_MCOUNTINHIBIT 12'h320
`define CSR_MSCRATCH      12'h340
`define CSR_MEPC          12'h341
`define CSR_MCAUSE        12'h342
`define CSR_MTVAL         12'h343
`define CSR_MIP           12'h344

// Machine and user counters
`define CSR_MCYCLE    12'hB00
`define CSR_MINSTRET  12'hB02
`define CSR_MCYCLEH   12'hB80
`define CSR_MINSTRETH 12'hB82
`define CSR_CYCLE     12'hC00
`define CSR_INSTRET   12'hC02
`define CSR_CYCLEH    12'hC80
`define CSR_INSTRETH  12'hC82

// Read-only machine information
`define CSR_MVENDORID  12'hF11
`define CSR_MARCHID    12'hF12
`define CSR_MIMPID     12'hF13
`define CSR_MHARTID    12'hF14
`define CSR_MCONFIGPTR 12'hF15

`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7
`define MSTATUS_MPP_LO   11  // MPP is bits 12:11
`define MSTATUS_MPRV_BIT 17
`define MSTATUS_TW_BIT   21

`define MIX_MSI_BIT 3
`define MIX_MTI_BIT 7
`define MIX_MEI_BIT 11

`define CNT_CY_BIT 0
`define CNT_IR_BIT 2

`define MSTATUS_RESET    32'h0020_0000  // TW set, MPP = U
`define MCOUNTEREN_RESET 32'h0000_0005  // CY and IR visible to U
`define MISA_VALUE       32'h4010_1100  // RV32 with I, M, U

`endif

/* hdl/csr_pkg.sv */
// Types shared by the CSR file modules
// Referenced by scoped name, e.g. csr_pkg::csr_op_t
`default_nettype none

package csr_pkg;

  // CSR instruction flavour
  typedef enum logic [1:0] {
    CSR_READ  = 2'b00,
    CSR_WRITE = 2'b01,
    CSR_SET   = 2'b10,
    CSR_CLEAR = 2'b11
  } csr_op_t;

  // Only U and M exist, 1 is folded into U by the controller
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_level_t;

  // Handshake controller
  typedef enum logic [1:0] {
    ST_IDLE   = 2'b00,
    ST_ACCESS = 2'b01,
    ST_ACK    = 2'b10
  } access_state_t;

endpackage

`default_nettype wire

/* hdl/csr_access_ctrl.sv */
// Request side of the CSR file: four-phase req/ack, request capture,
// read-modify-write value and the privilege / read-only checks
`timescale 1ns/1ns
`default_nettype none
`include "csr_macros.svh"

module csr_access_ctrl (
  input  wire logic                     CLK,
  input  wire logic                     nRST,
  input  wire logic                     req,
  input  wire logic [`CSR_ADDR_W-1:0]   csr_addr,
  input  csr_pkg::csr_op_t              csr_op,
  input  wire logic [`CSR_XLEN-1:0]     wdata,
  input  csr_pkg::priv_level_t          priv,
  input  wire logic [`CSR_XLEN-1:0]     old_val,
  input  wire logic                     addr_invalid,
  output logic                          ack,
  output logic [`CSR_XLEN-1:0]          rdata,
  output logic                          illegal,
  output logic [`CSR_ADDR_W-1:0]        acc_addr,
  output csr_pkg::priv_level_t          acc_priv,
  output logic                          wr_en,
  output logic [`CSR_ADDR_W-1:0]        wr_addr,
  output logic [`CSR_XLEN-1:0]          wr_data
);

  csr_pkg::access_state_t state, state_next;
  csr_pkg::csr_op_t       acc_op;
  logic [`CSR_XLEN-1:0]   acc_wdata;
  logic [`CSR_XLEN-1:0]   new_val;
  logic                   is_read;
  logic                   priv_fail;
  logic                   ro_fail;
  logic                   illegal_c;

  always_comb begin
    state_next = state;
    case (state)
      csr_pkg::ST_IDLE:   if (req) state_next = csr_pkg::ST_ACCESS;
      csr_pkg::ST_ACCESS: state_next = csr_pkg::ST_ACK;  // Single access cycle
      csr_pkg::ST_ACK:    if (!req) state_next = csr_pkg::ST_IDLE;
      default:            state_next = csr_pkg::ST_IDLE;
    endcase
  end

  // Read-modify-write result
  always_comb begin
    case (acc_op)
      csr_pkg::CSR_WRITE: new_val = acc_wdata;
      csr_pkg::CSR_SET:   new_val = old_val | acc_wdata;
      csr_pkg::CSR_CLEAR: new_val = old_val & ~acc_wdata;
      default:            new_val = old_val;
    endcase
  end

  assign is_read   = (acc_op == csr_pkg::CSR_READ);
  assign priv_fail = (acc_addr[9:8] > acc_priv);             // Level field above hart level
  assign ro_fail   = (acc_addr[11:10] == 2'b11) && !is_read;  // Read-only space
  assign illegal_c = priv_fail || ro_fail || addr_invalid;

  // Strobe lives for the ST_ACCESS cycle so the write lands with ack
  assign wr_en   = (state == csr_pkg::ST_ACCESS) && !illegal_c && !is_read;
  assign wr_addr = acc_addr;
  assign wr_data = new_val;

  assign ack = (state == csr_pkg::ST_ACK);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state   <= csr_pkg::ST_IDLE;
      illegal <= 1'b0;
    end else begin
      state <= state_next;
      if (state == csr_pkg::ST_ACCESS) begin
        illegal <= illegal_c;
      end
    end
  end

  // Request and response payload
  always_ff @(posedge CLK) begin
    if (state == csr_pkg::ST_IDLE && req) begin
      acc_addr  <= csr_addr;
      acc_op    <= csr_op;
      acc_wdata <= wdata;
      acc_priv  <= (priv == csr_pkg::PRIV_M) ? csr_pkg::PRIV_M : csr_pkg::PRIV_U;
    end
    if (state == csr_pkg::ST_ACCESS) begin
      rdata <= illegal_c ? '0 : old_val;  // Nothing leaks on a refused access
    end
  end

endmodule

`default_nettype wire

/* hdl/csr_machine_regs.sv */
// Writable machine trap and status registers with WARL legalization
// Software writes come from the access controller, trap_load from trap logic
`timescale 1ns/1ns
`default_nettype none
`include "csr_macros.svh"

module csr_machine_regs (
  input  wire logic                   CLK,
  input  wire logic                   nRST,
  input  wire logic                   wr_en,
  input  wire logic [`CSR_ADDR_W-1:0] wr_addr,
  input  wire logic [`CSR_XLEN-1:0]   wr_data,
  input  wire logic                   trap_load,
  input  wire logic [`CSR_XLEN-1:0]   trap_mepc,
  input  wire logic [`CSR_XLEN-1:0]   trap_mcause,
  input  wire logic [`CSR_XLEN-1:0]   trap_mtval,
  output logic [`CSR_XLEN-1:0]        mstatus,
  output logic [`CSR_XLEN-1:0]        mtvec,
  output logic [`CSR_XLEN-1:0]        mie,
  output logic [`CSR_XLEN-1:0]        mip,
  output logic [`CSR_XLEN-1:0]        mscratch,
  output logic [`CSR_XLEN-1:0]        mepc,
  output logic [`CSR_XLEN-1:0]        mcause,
  output logic [`CSR_XLEN-1:0]        mtval,
  output logic [`CSR_XLEN-1:0]        mcounteren,
  output logic [`CSR_XLEN-1:0]        mcountinhibit
);

  // Single-bit fields of mstatus that are stored as written
  localparam logic [`CSR_XLEN-1:0] MSTATUS_MASK =
    (`CSR_XLEN'(1) << `MSTATUS_MIE_BIT)  | (`CSR_XLEN'(1) << `MSTATUS_MPIE_BIT) |
    (`CSR_XLEN'(1) << `MSTATUS_MPRV_BIT) | (`CSR_XLEN'(1) << `MSTATUS_TW_BIT);
  localparam logic [`CSR_XLEN-1:0] INT_MASK =
    (`CSR_XLEN'(1) << `MIX_MSI_BIT) | (`CSR_XLEN'(1) << `MIX_MTI_BIT) |
    (`CSR_XLEN'(1) << `MIX_MEI_BIT);
  localparam logic [`CSR_XLEN-1:0] CNT_MASK =
    (`CSR_XLEN'(1) << `CNT_CY_BIT) | (`CSR_XLEN'(1) << `CNT_IR_BIT);

  logic [1:0]           mpp_legal;
  logic [`CSR_XLEN-1:0] mstatus_wr;
  logic [`CSR_XLEN-1:0] mtvec_wr;

  // S and reserved MPP values collapse to U
  assign mpp_legal = (wr_data[`MSTATUS_MPP_LO +: 2] == 2'b11) ? 2'b11 : 2'b00;

  always_comb begin
    mstatus_wr = wr_data & MSTATUS_MASK;
    mstatus_wr[`MSTATUS_MPP_LO +: 2] = mpp_legal;
  end

  // Only direct and vectored modes
  assign mtvec_wr = {wr_data[`CSR_XLEN-1:2], (wr_data[1:0] > 2'b01) ? 2'b00 : wr_data[1:0]};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus       <= `MSTATUS_RESET;
      mtvec         <= '0;
      mie           <= '0;
      mip           <= '0;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
      mcounteren    <= `MCOUNTEREN_RESET;
      mcountinhibit <= '0;
    end else begin
      if (wr_en) begin
        case (wr_addr)
          `CSR_MSTATUS:       mstatus <= mstatus_wr;
          `CSR_MTVEC:         mtvec <= mtvec_wr;
          `CSR_MIE:           mie <= wr_data & INT_MASK;
          `CSR_MIP:           mip <= wr_data & INT_MASK;
          `CSR_MSCRATCH:      mscratch <= wr_data;
          `CSR_MEPC:          mepc <= wr_data;
          `CSR_MCAUSE:        mcause <= wr_data;
          `CSR_MTVAL:         mtval <= wr_data;
          `CSR_MCOUNTEREN:    mcounteren <= wr_data & CNT_MASK;
          `CSR_MCOUNTINHIBIT: mcountinhibit <= wr_data & CNT_MASK;
          default: ;  // Counters and read-only CSRs live elsewhere
        endcase
      end
      // Trap entry overrides a software write in the same cycle
      if (trap_load) begin
        mepc   <= trap_mepc;
        mcause <= trap_mcause;
        mtval  <= trap_mtval;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/csr_counters.sv */
// 64-bit cycle and instret counters with inhibit and half-word writes
`timescale 1ns/1ns
`default_nettype none
`include "csr_macros.svh"

module csr_counters (
  input  wire logic                   CLK,
  input  wire logic                   nRST,
  input  wire logic                   inst_ret,
  input  wire logic                   inhibit_cy,
  input  wire logic                   inhibit_ir,
  input  wire logic                   wr_en,
  input  wire logic [`CSR_ADDR_W-1:0] wr_addr,
  input  wire logic [`CSR_XLEN-1:0]   wr_data,
  output logic [63:0]                 cycle_count,
  output logic [63:0]                 instret_count
);

  // Write to a half wins over the increment, the other half is kept
  function automatic logic [63:0] count_next(input logic [63:0] cur,
                                             input logic step,
                                             input logic wr_lo,
                                             input logic wr_hi,
                                             input logic [`CSR_XLEN-1:0] data);
    logic [63:0] nxt;
    nxt = cur + {63'd0, step};
    if (wr_lo) nxt = {cur[63:32], data};
    if (wr_hi) nxt = {data, cur[31:0]};
    return nxt;
  endfunction

  logic wr_cy_lo, wr_cy_hi, wr_ir_lo, wr_ir_hi;

  assign wr_cy_lo = wr_en && (wr_addr == `CSR_MCYCLE);
  assign wr_cy_hi = wr_en && (wr_addr == `CSR_MCYCLEH);
  assign wr_ir_lo = wr_en && (wr_addr == `CSR_MINSTRET);
  assign wr_ir_hi = wr_en && (wr_addr == `CSR_MINSTRETH);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cycle_count   <= '0;
      instret_count <= '0;
    end else begin
      cycle_count   <= count_next(cycle_count, !inhibit_cy, wr_cy_lo, wr_cy_hi, wr_data);
      instret_count <= count_next(instret_count, inst_ret && !inhibit_ir,
                                  wr_ir_lo, wr_ir_hi, wr_data);
    end
  end

endmodule

`default_nettype wire

/* hdl/csr_read_mux.sv */
// Old-value selection by address, with mcounteren gating of user counter reads
// Flags unknown addresses and refused reads through addr_invalid
`timescale 1ns/1ns
`default_nettype none
`include "csr_macros.svh"

module csr_read_mux #(
  parameter int HART_ID = 0
) (
  input  wire logic [`CSR_ADDR_W-1:0] acc_addr,
  input  csr_pkg::priv_level_t        acc_priv,
  input  wire logic [`CSR_XLEN-1:0]   mstatus,
  input  wire logic [`CSR_XLEN-1:0]   mtvec,
  input  wire logic [`CSR_XLEN-1:0]   mie,
  input  wire logic [`CSR_XLEN-1:0]   mip,
  input  wire logic [`CSR_XLEN-1:0]   mscratch,
  input  wire logic [`CSR_XLEN-1:0]   mepc,
  input  wire logic [`CSR_XLEN-1:0]   mcause,
  input  wire logic [`CSR_XLEN-1:0]   mtval,
  input  wire logic [`CSR_XLEN-1:0]   mcounteren,
  input  wire logic [`CSR_XLEN-1:0]   mcountinhibit,
  input  wire logic [63:0]            cycle_count,
  input  wire logic [63:0]            instret_count,
  output logic [`CSR_XLEN-1:0]        old_val,
  output logic                        addr_invalid
);

  localparam logic [`CSR_XLEN-1:0] HART_ID_VAL = `CSR_XLEN'(HART_ID);

  logic user_mode;
  logic cy_refused;
  logic ir_refused;

  assign user_mode  = (acc_priv == csr_pkg::PRIV_U);
  assign cy_refused = user_mode && !mcounteren[`CNT_CY_BIT];
  assign ir_refused = user_mode && !mcounteren[`CNT_IR_BIT];

  always_comb begin
    old_val      = '0;
    addr_invalid = 1'b0;
    case (acc_addr)
      `CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID,
      `CSR_MCONFIGPTR, `CSR_MSTATUSH: old_val = '0;  // Hardwired zero
      `CSR_MHARTID:       old_val = HART_ID_VAL;
      `CSR_MISA:          old_val = `MISA_VALUE;
      `CSR_MSTATUS:       old_val = mstatus;
      `CSR_MTVEC:         old_val = mtvec;
      `CSR_MIE:           old_val = mie;
      `CSR_MIP:           old_val = mip;
      `CSR_MSCRATCH:      old_val = mscratch;
      `CSR_MEPC:          old_val = mepc;
      `CSR_MCAUSE:        old_val = mcause;
      `CSR_MTVAL:         old_val = mtval;
      `CSR_MCOUNTEREN:    old_val = mcounteren;
      `CSR_MCOUNTINHIBIT: old_val = mcountinhibit;
      `CSR_MCYCLE:        old_val = cycle_count[31:0];
      `CSR_MCYCLEH:       old_val = cycle_count[63:32];
      `CSR_MINSTRET:      old_val = instret_count[31:0];
      `CSR_MINSTRETH:     old_val = instret_count[63:32];
      // User shadows, visible only if mcounteren allows
      `CSR_CYCLE: begin
        if (cy_refused) addr_invalid = 1'b1;
        else old_val = cycle_count[31:0];
      end
      `CSR_CYCLEH: begin
        if (cy_refused) addr_invalid = 1'b1;
        else old_val = cycle_count[63:32];
      end
      `CSR_INSTRET: begin
        if (ir_refused) addr_invalid = 1'b1;
        else old_val = instret_count[31:0];
      end
      `CSR_INSTRETH: begin
        if (ir_refused) addr_invalid = 1'b1;
        else old_val = instret_count[63:32];
      end
      default: addr_invalid = 1'b1;  // Not implemented here
    endcase
  end

endmodule

`default_nettype wire

/* hdl/csr_file_top.sv */
// Machine-mode CSR file for an M/U hart, reached through a four-phase req/ack port
// Also exposes live trap state and accepts trap-side loads of mepc/mcause/mtval
`timescale 1ns/1ns
`default_nettype none
`include "csr_macros.svh"

module csr_file_top #(
  parameter int HART_ID = 0
) (
  input  wire logic                   CLK,
  input  wire logic                   nRST,
  input  wire logic                   req,
  input  wire logic [`CSR_ADDR_W-1:0] csr_addr,
  input  csr_pkg::csr_op_t            csr_op,
  input  wire logic [`CSR_XLEN-1:0]   wdata,
  input  csr_pkg::priv_level_t        priv,
  output logic                        ack,
  output logic [`CSR_XLEN-1:0]        rdata,
  output logic                        illegal,
  input  wire logic                   inst_ret,
  input  wire logic                   trap_load,
  input  wire logic [`CSR_XLEN-1:0]   trap_mepc,
  input  wire logic [`CSR_XLEN-1:0]   trap_mcause,
  input  wire logic [`CSR_XLEN-1:0]   trap_mtval,
  output logic [`CSR_XLEN-1:0]        mstatus,
  output logic [`CSR_XLEN-1:0]        mtvec,
  output logic [`CSR_XLEN-1:0]        mepc,
  output logic [`CSR_XLEN-1:0]        mie,
  output logic [`CSR_XLEN-1:0]        mip
);

  logic [`CSR_ADDR_W-1:0] acc_addr;
  csr_pkg::priv_level_t   acc_priv;
  logic [`CSR_XLEN-1:0]   old_val;
  logic                   addr_invalid;
  logic                   wr_en;
  logic [`CSR_ADDR_W-1:0] wr_addr;
  logic [`CSR_XLEN-1:0]   wr_data;
  logic [`CSR_XLEN-1:0]   mscratch, mcause, mtval;
  logic [`CSR_XLEN-1:0]   mcounteren, mcountinhibit;
  logic [63:0]            cycle_count, instret_count;

  csr_access_ctrl csr_access_ctrl_inst (
    .CLK, .nRST, .req, .csr_addr, .csr_op, .wdata, .priv,
    .old_val, .addr_invalid,
    .ack, .rdata, .illegal,
    .acc_addr, .acc_priv,
    .wr_en, .wr_addr, .wr_data
  );

  csr_machine_regs csr_machine_regs_inst (
    .CLK, .nRST, .wr_en, .wr_addr, .wr_data,
    .trap_load, .trap_mepc, .trap_mcause, .trap_mtval,
    .mstatus, .mtvec, .mie, .mip, .mscratch, .mepc, .mcause, .mtval,
    .mcounteren, .mcountinhibit
  );

  csr_counters csr_counters_inst (
    .CLK, .nRST, .inst_ret,
    .inhibit_cy (mcountinhibit[`CNT_CY_BIT]),
    .inhibit_ir (mcountinhibit[`CNT_IR_BIT]),
    .wr_en, .wr_addr, .wr_data,
    .cycle_count, .instret_count
  );

  csr_read_mux #(.HART_ID(HART_ID)) csr_read_mux_inst (
    .acc_addr, .acc_priv,
    .mstatus, .mtvec, .mie, .mip, .mscratch, .mepc, .mcause, .mtval,
    .mcounteren, .mcountinhibit,
    .cycle_count, .instret_count,
    .old_val, .addr_invalid
  );

endmodule

`default_nettype wire

/* bench/csr_file_tb.sv */
// Self-checking testbench for the machine CSR file
// Drives four-phase accesses and trap loads and compares against a shadow model
`timescale 1ns/1ns
`default_nettype none
`include "csr_macros.svh"

module csr_file_tb;

  localparam int NUM_TESTS = 6;
  localparam int HART      = 5;

  logic                   CLK;
  logic                   nRST;
  logic                   req;
  logic [`CSR_ADDR_W-1:0] csr_addr;
  csr_pkg::csr_op_t       csr_op;
  logic [`CSR_XLEN-1:0]   wdata;
  csr_pkg::priv_level_t   priv;
  logic                   ack;
  logic [`CSR_XLEN-1:0]   rdata;
  logic                   illegal;
  logic                   inst_ret;
  logic                   trap_load;
  logic [`CSR_XLEN-1:0]   trap_mepc;
  logic [`CSR_XLEN-1:0]   trap_mcause;
  logic [`CSR_XLEN-1:0]   trap_mtval;
  logic [`CSR_XLEN-1:0]   mstatus;
  logic [`CSR_XLEN-1:0]   mtvec;
  logic [`CSR_XLEN-1:0]   mepc;
  logic [`CSR_XLEN-1:0]   mie;
  logic [`CSR_XLEN-1:0]   mip;

  integer seed = 32'h9568;
  string  cur_test = "reset";
  int     test_errors = 0;
  int     pass_count = 0;
  int     fail_count = 0;
  int     hs_phase;  // 0 idle, 1 access, 2 ack

  csr_file_top #(.HART_ID(HART)) csr_file_top_inst (
    .CLK, .nRST, .req, .csr_addr, .csr_op, .wdata, .priv,
    .ack, .rdata, .illegal, .inst_ret,
    .trap_load, .trap_mepc, .trap_mcause, .trap_mtval,
    .mstatus, .mtvec, .mepc, .mie, .mip
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  initial begin
    #(NUM_TESTS * 40 * 6 * 100);
    $display("Watchdog expired: the run hung waiting on the DUT");
    $display("Simulation failed");
    $finish;
  end

  // Expected handshake phase, req is stable at the rising edge
  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      hs_phase <= 0;
    end else begin
      case (hs_phase)
        0: if (req) hs_phase <= 1;
        1: hs_phase <= 2;          // Response registered one cycle later
        default: if (!req) hs_phase <= 0;
      endcase
    end
  end

  // ack must rise exactly one cycle after req was sampled
  always @(negedge CLK) begin
    if (nRST) begin
      assert (ack === (hs_phase == 2)) else begin
        $display("[FAIL] %s ack timing: expected %b actual %b", cur_test, hs_phase == 2, ack);
        test_errors++;
      end
    end
  end

  // Shadow legalization rules
  function automatic logic [31:0] legal_mstatus(input logic [31:0] w);
    logic [31:0] v;
    v     = 32'd0;
    v[3]  = w[3];   // MIE
    v[7]  = w[7];   // MPIE
    v[17] = w[17];  // MPRV
    v[21] = w[21];  // TW
    if (w[12:11] == 2'b00 || w[12:11] == 2'b11) begin
      v[12:11] = w[12:11];
    end
    return v;
  endfunction

  function automatic logic [31:0] legal_mtvec(input logic [31:0] w);
    logic [31:0] v;
    v = w;
    if (w[1]) begin
      v[1:0] = 2'b00;  // Modes 2 and 3 are reserved
    end
    return v;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s %s: expected %h actual %h", cur_test, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic do_access(input logic [11:0] addr, input csr_pkg::csr_op_t op,
                           input logic [31:0] data, input csr_pkg::priv_level_t lvl,
                           output logic [31:0] rd, output logic ill);
    int waited;
    @(negedge CLK);
    csr_addr = addr;
    csr_op   = op;
    wdata    = data;
    priv     = lvl;
    req      = 1'b1;
    waited   = 0;
    do begin
      @(negedge CLK);
      waited++;
    end while (!ack && waited < 10);
    if (!ack) begin
      $display("No ack for address %h in test %s", addr, cur_test);
      test_errors++;
    end
    rd  = rdata;
    ill = illegal;
    req = 1'b0;
    waited = 0;
    while (ack && waited < 10) begin
      @(negedge CLK);
      waited++;
    end
    if (ack) begin
      $display("ack stuck high after req fell in test %s", cur_test);
      test_errors++;
    end
  endtask

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        ill;
    do_access(addr, csr_pkg::CSR_WRITE, data, csr_pkg::PRIV_M, rd, ill);
    check_value("write accepted", 32'd0, {31'd0, ill});
  endtask

  task automatic read_reg(input logic [11:0] addr, output logic [31:0] rd);
    logic ill;
    do_access(addr, csr_pkg::CSR_READ, 32'd0, csr_pkg::PRIV_M, rd, ill);
    check_value("read accepted", 32'd0, {31'd0, ill});
  endtask

  task automatic expect_read(input string what, input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    read_reg(addr, rd);
    check_value(what, exp, rd);
  endtask

  task automatic expect_refused(input string what, input logic [11:0] addr,
                                input csr_pkg::csr_op_t op, input csr_pkg::priv_level_t lvl);
    logic [31:0] rd;
    logic        ill;
    do_access(addr, op, 32'hFFFF_FFFF, lvl, rd, ill);
    check_value({what, " illegal"}, 32'd1, {31'd0, ill});
    check_value({what, " rdata"}, 32'd0, rd);
  endtask

  task automatic pulse_inst_ret(input int n);
    repeat (n) begin
      @(negedge CLK);
      inst_ret = 1'b1;
      @(negedge CLK);
      inst_ret = 1'b0;
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    #1;  // Let the ack monitor finish at this edge
    if (test_errors == 0) begin
      pass_count++;
      $display("test %s: PASS", cur_test);
    end else begin
      fail_count++;
      $display("test %s: FAIL (%0d errors)", cur_test, test_errors);
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] r;
    logic [31:0] model;
    logic [31:0] prior;
    logic [31:0] first;
    logic [31:0] tm_epc;
    logic [31:0] tm_cause;
    logic [31:0] tm_val;
    logic        ill;
    csr_pkg::csr_op_t op;

    nRST        = 1'b0;
    req         = 1'b0;
    csr_addr    = '0;
    csr_op      = csr_pkg::CSR_READ;
    wdata       = '0;
    priv        = csr_pkg::PRIV_M;
    inst_ret    = 1'b0;
    trap_load   = 1'b0;
    trap_mepc   = '0;
    trap_mcause = '0;
    trap_mtval  = '0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;

    start_test("reset_constants");
    expect_read("mstatus", `CSR_MSTATUS, 32'h0020_0000);
    expect_read("mcounteren", `CSR_MCOUNTEREN, 32'h5);
    expect_read("misa", `CSR_MISA, `MISA_VALUE);
    expect_read("mhartid", `CSR_MHARTID, HART);
    expect_read("mvendorid", `CSR_MVENDORID, 32'd0);
    expect_read("marchid", `CSR_MARCHID, 32'd0);
    expect_read("mimpid", `CSR_MIMPID, 32'd0);
    expect_read("mstatush", `CSR_MSTATUSH, 32'd0);
    end_test();

    start_test("write_set_clear");
    model = $random(seed);
    write_reg(`CSR_MSCRATCH, model);
    repeat (16) begin
      r     = $random(seed);
      wdata = $random(seed);
      prior = model;
      case (r[1:0])
        2'b01: begin
          op    = csr_pkg::CSR_SET;
          model = model | wdata;
        end
        2'b10: begin
          op    = csr_pkg::CSR_CLEAR;
          model = model & ~wdata;
        end
        default: begin
          op    = csr_pkg::CSR_WRITE;
          model = wdata;
        end
      endcase
      do_access(`CSR_MSCRATCH, op, wdata, csr_pkg::PRIV_M, rd, ill);
      check_value("prior value", prior, rd);
      check_value("illegal", 32'd0, {31'd0, ill});
    end
    expect_read("final mscratch", `CSR_MSCRATCH, model);
    end_test();

    start_test("legalization");
    write_reg(`CSR_MSTATUS, 32'hFFFF_FFFF);
    expect_read("mstatus all ones", `CSR_MSTATUS, 32'h0022_1888);
    check_value("mstatus port", legal_mstatus(32'hFFFF_FFFF), mstatus);
    write_reg(`CSR_MSTATUS, 32'h0000_0800);  // MPP = 1
    read_reg(`CSR_MSTATUS, rd);
    check_value("mstatus MPP", 32'd0, {30'd0, rd[12:11]});
    check_value("mstatus", legal_mstatus(32'h0000_0800), rd);
    write_reg(`CSR_MTVEC, 32'h8000_0103);
    expect_read("mtvec mode", `CSR_MTVEC, legal_mtvec(32'h8000_0103));
    check_value("mtvec port", 32'h8000_0100, mtvec);
    write_reg(`CSR_MIE, 32'hFFFF_FFFF);
    expect_read("mie", `CSR_MIE, 32'h0000_0888);
    check_value("mie port", 32'h0000_0888, mie);
    write_reg(`CSR_MIP, 32'hFFFF_FFFF);
    expect_read("mip", `CSR_MIP, 32'h0000_0888);
    check_value("mip port", 32'h0000_0888, mip);
    end_test();

    start_test("illegal_access");
    write_reg(`CSR_MSCRATCH, 32'h1234_5678);
    expect_refused("user write mscratch", `CSR_MSCRATCH, csr_pkg::CSR_WRITE, csr_pkg::PRIV_U);
    expect_read("mscratch kept", `CSR_MSCRATCH, 32'h1234_5678);
    expect_refused("write mhartid", `CSR_MHARTID, csr_pkg::CSR_WRITE, csr_pkg::PRIV_M);
    expect_read("mhartid kept", `CSR_MHARTID, HART);
    expect_refused("unknown address", 12'h7C0, csr_pkg::CSR_READ, csr_pkg::PRIV_M);
    write_reg(`CSR_MCOUNTEREN, 32'h4);  // CY hidden from U
    expect_refused("user cycle read", `CSR_CYCLE, csr_pkg::CSR_READ, csr_pkg::PRIV_U);
    write_reg(`CSR_MCOUNTEREN, 32'h5);
    do_access(`CSR_CYCLE, csr_pkg::CSR_READ, 32'd0, csr_pkg::PRIV_U, rd, ill);
    check_value("user cycle read enabled", 32'd0, {31'd0, ill});
    end_test();

    start_test("counters");
    model = $random(seed);
    write_reg(`CSR_MINSTRET, model);
    pulse_inst_ret(5);
    expect_read("minstret after pulses", `CSR_MINSTRET, model + 32'd5);
    write_reg(`CSR_MCOUNTINHIBIT, 32'h4);
    read_reg(`CSR_MINSTRET, first);
    pulse_inst_ret(3);
    expect_read("minstret inhibited", `CSR_MINSTRET, first);
    write_reg(`CSR_MCOUNTINHIBIT, 32'h5);
    read_reg(`CSR_MCYCLE, first);
    expect_read("mcycle inhibited", `CSR_MCYCLE, first);
    write_reg(`CSR_MCOUNTINHIBIT, 32'h0);
    read_reg(`CSR_MCYCLE, first);
    read_reg(`CSR_MCYCLE, rd);
    assert (rd > first) else begin
      $display("[FAIL] %s mcycle running: expected above %h actual %h", cur_test, first, rd);
      test_errors++;
    end
    end_test();

    start_test("trap_load");
    tm_epc   = $random(seed);
    tm_cause = $random(seed);
    tm_val   = $random(seed);
    @(negedge CLK);
    trap_load   = 1'b1;
    trap_mepc   = tm_epc;
    trap_mcause = tm_cause;
    trap_mtval  = tm_val;
    @(negedge CLK);
    trap_load = 1'b0;
    check_value("mepc port", tm_epc, mepc);
    expect_read("mepc", `CSR_MEPC, tm_epc);
    expect_read("mcause", `CSR_MCAUSE, tm_cause);
    expect_read("mtval", `CSR_MTVAL, tm_val);
    prior  = tm_epc;
    tm_epc = $random(seed);
    // Trap load lands on the same edge as the write commit
    fork
      do_access(`CSR_MEPC, csr_pkg::CSR_WRITE, 32'hBAD0_0000, csr_pkg::PRIV_M, rd, ill);
      begin
        @(negedge CLK);
        @(negedge CLK);
        trap_load = 1'b1;
        trap_mepc = tm_epc;
        @(negedge CLK);
        trap_load = 1'b0;
      end
    join
    check_value("colliding write prior", prior, rd);
    check_value("mepc port after collision", tm_epc, mepc);
    expect_read("mepc after collision", `CSR_MEPC, tm_epc);
    end_test();

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
hdl/csr_pkg.sv
hdl/csr_access_ctrl.sv
hdl/csr_machine_regs.sv
hdl/csr_counters.sv
hdl/csr_read_mux.sv
hdl/csr_file_top.sv
bench/csr_file_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Iinclude
TOP       = csr_file_tb
FILELIST  = sources.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "RUN FAILED"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then echo "RUN INCOMPLETE"; exit 1; fi
	@echo "RUN PASSED"

clean:
	rm -rf $(OBJDIR) $(LOG)
